/* hdl/stream_pkg.sv */
/*
 * stream FIFO definitions
 * status flags shared by the FIFOs, the decoupler and the top,
 * plus the default FIFO depth
 */

package stream_pkg;

  // default number of entries in each decoupling FIFO
  localparam int unsigned DEFAULT_FIFO_DEPTH = 4;

  // FIFO status as seen by the surrounding logic
  typedef struct packed {
    logic empty;         // no entry stored
    logic full;          // no free slot left
    logic push_pending;  // push offered while full
  } fifo_flags_t;

endpackage

/* hdl/tcdm_pkg.sv */
/*
 * TCDM memory port definitions
 * widths of the data memory port and the request and response payloads
 */

package tcdm_pkg;

  localparam int unsigned ADDR_W    = 10;          // byte address
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned USER_W    = 4;
  localparam int unsigned BE_W      = DATA_W / 8;  // one enable per byte
  localparam int unsigned MEM_WORDS = 256;         // bank size in words

  typedef logic [ADDR_W-1:0] tcdm_addr_t;
  typedef logic [DATA_W-1:0] tcdm_data_t;
  typedef logic [BE_W-1:0]   tcdm_be_t;
  typedef logic [USER_W-1:0] tcdm_user_t;

  // request payload, carried through the outgoing FIFO
  typedef struct packed {
    tcdm_addr_t add;
    tcdm_data_t data;
    tcdm_be_t   be;
    logic       wen;   // low for a write
    tcdm_user_t user;
  } tcdm_req_t;

  // response payload, carried through the incoming FIFO
  typedef struct packed {
    tcdm_data_t data;
    tcdm_user_t user;  // echoed from the request
  } tcdm_rsp_t;

endpackage

/* hdl/stream_fifo.sv */
/*
 * stream FIFO
 * registered valid/ready circular buffer with synchronous clear,
 * no fall-through, reports empty, full and pushes offered while full
 */

`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DEPTH     = stream_pkg::DEFAULT_FIFO_DEPTH,
  parameter type         payload_t = logic [31:0]
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,

  input  logic                    push_valid_i,
  input  payload_t                push_data_i,
  output logic                    push_ready_o,

  output logic                    pop_valid_o,
  output payload_t                pop_data_o,
  input  logic                    pop_ready_i,

  output stream_pkg::fifo_flags_t flags_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];  // storage, no reset needed
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);

  assign push = push_valid_i & ~full;
  assign pop  = pop_ready_i & ~empty;

  assign push_ready_o = ~full;
  assign pop_valid_o  = ~empty;
  assign pop_data_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle, or in and out together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

  assign flags_o = '{
    empty:        empty,
    full:         full,
    push_pending: push_valid_i & full
  };

endmodule

/* hdl/tcdm_fifo_decoupler.sv */
/*
 * TCDM FIFO decoupler
 * queues requests toward the memory and responses back to the core,
 * issues only while the response FIFO has room
 */

`timescale 1ns/1ps

module tcdm_fifo_decoupler #(
  parameter int unsigned FIFO_DEPTH = stream_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,

  // processing element side
  input  logic                    req_i,
  input  tcdm_pkg::tcdm_req_t     req_payload_i,
  output logic                    gnt_o,
  output logic                    r_valid_o,
  output tcdm_pkg::tcdm_rsp_t     r_payload_o,
  input  logic                    lrdy_i,

  // memory side
  output logic                    mem_req_o,
  output tcdm_pkg::tcdm_req_t     mem_req_payload_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_r_valid_i,
  input  tcdm_pkg::tcdm_rsp_t     mem_r_payload_i,

  output stream_pkg::fifo_flags_t flags_o
);

  import stream_pkg::*;
  import tcdm_pkg::*;

  fifo_flags_t flags_outgoing;
  fifo_flags_t flags_incoming;

  logic        outgoing_pop_valid;
  logic        outgoing_pop_ready;
  logic        incoming_not_full;
  logic        incoming_push_valid;
  tcdm_rsp_t   incoming_push_data;

  logic        capture_valid_q;  // response waiting for a free slot
  tcdm_rsp_t   capture_data_q;

  // live response wins over the held one
  assign incoming_push_valid = mem_r_valid_i | capture_valid_q;
  assign incoming_push_data  = mem_r_valid_i ? mem_r_payload_i : capture_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      capture_valid_q <= 1'b0;
    end else if (clear_i) begin
      capture_valid_q <= 1'b0;
    end else if (mem_r_valid_i && incoming_not_full) begin
      capture_valid_q <= 1'b0;  // live one goes straight in
    end else if (mem_r_valid_i) begin
      capture_valid_q <= 1'b1;  // FIFO full, park it
    end else if (capture_valid_q && incoming_not_full) begin
      capture_valid_q <= 1'b0;  // parked one drained
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_r_valid_i) capture_data_q <= mem_r_payload_i;
  end

  stream_fifo #(
    .DEPTH     ( FIFO_DEPTH ),
    .payload_t ( tcdm_rsp_t )
  ) u_fifo_incoming (
    .clk_i        ( clk_i               ),
    .rst_ni       ( rst_ni              ),
    .clear_i      ( clear_i             ),
    .push_valid_i ( incoming_push_valid ),
    .push_data_i  ( incoming_push_data  ),
    .push_ready_o ( incoming_not_full   ),
    .pop_valid_o  ( r_valid_o           ),
    .pop_data_o   ( r_payload_o         ),
    .pop_ready_i  ( lrdy_i              ),
    .flags_o      ( flags_incoming      )
  );

  // a request leaves only when its response is sure to find room
  assign mem_req_o          = outgoing_pop_valid & incoming_not_full;
  assign outgoing_pop_ready = mem_gnt_i & incoming_not_full;

  stream_fifo #(
    .DEPTH     ( FIFO_DEPTH ),
    .payload_t ( tcdm_req_t )
  ) u_fifo_outgoing (
    .clk_i        ( clk_i              ),
    .rst_ni       ( rst_ni             ),
    .clear_i      ( clear_i            ),
    .push_valid_i ( req_i              ),
    .push_data_i  ( req_payload_i      ),
    .push_ready_o ( gnt_o              ),
    .pop_valid_o  ( outgoing_pop_valid ),
    .pop_data_o   ( mem_req_payload_o  ),
    .pop_ready_i  ( outgoing_pop_ready ),
    .flags_o      ( flags_outgoing     )
  );

  assign flags_o = '{
    empty:        flags_outgoing.empty & flags_incoming.empty,
    full:         flags_outgoing.full,
    push_pending: flags_outgoing.push_pending
  };

endmodule

/* hdl/tcdm_sram_bank.sv */
/*
 * TCDM SRAM bank
 * single-port word memory with byte-enable writes, answers each
 * granted request one cycle later through a response register
 */

`timescale 1ns/1ps

module tcdm_sram_bank (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                req_i,
  input  tcdm_pkg::tcdm_req_t req_payload_i,
  output logic                gnt_o,

  output logic                r_valid_o,
  output tcdm_pkg::tcdm_rsp_t r_payload_o
);

  import tcdm_pkg::*;

  localparam int unsigned IDX_W = ADDR_W - 2;  // word index, byte offset dropped

  tcdm_data_t       mem_q [MEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  tcdm_data_t       word_old;
  tcdm_data_t       word_new;  // contents after the access
  logic             access;
  logic             r_valid_q;
  tcdm_rsp_t        rsp_q;

  // the response register is always drained by the requester,
  // so it never holds an unaccepted response and the bank never stalls
  assign gnt_o  = 1'b1;
  assign access = req_i & gnt_o;

  assign word_idx = req_payload_i.add[ADDR_W-1:2];
  assign word_old = mem_q[word_idx];

  always_comb begin
    word_new = word_old;
    if (!req_payload_i.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req_payload_i.be[b]) begin
          word_new[8*b +: 8] = req_payload_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !req_payload_i.wen) mem_q[word_idx] <= word_new;
    if (access) rsp_q <= '{data: word_new, user: req_payload_i.user};
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= access;  // one-cycle pulse per grant
    end
  end

  assign r_valid_o   = r_valid_q;
  assign r_payload_o = rsp_q;

endmodule

/* hdl/tcdm_fifo_subsystem.sv */
/*
 * TCDM FIFO subsystem
 * processing element port decoupled from one SRAM bank
 */

`timescale 1ns/1ps

module tcdm_fifo_subsystem #(
  parameter int unsigned FIFO_DEPTH = stream_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,

  input  logic                    req_i,
  input  tcdm_pkg::tcdm_req_t     req_payload_i,
  output logic                    gnt_o,
  output logic                    r_valid_o,
  output tcdm_pkg::tcdm_rsp_t     r_payload_o,
  input  logic                    lrdy_i,

  output stream_pkg::fifo_flags_t flags_o
);

  import tcdm_pkg::*;

  logic      mem_req;
  tcdm_req_t mem_req_payload;
  logic      mem_gnt;
  logic      mem_r_valid;
  tcdm_rsp_t mem_r_payload;

  tcdm_fifo_decoupler #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_decoupler (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .clear_i           ( clear_i         ),
    .req_i             ( req_i           ),
    .req_payload_i     ( req_payload_i   ),
    .gnt_o             ( gnt_o           ),
    .r_valid_o         ( r_valid_o       ),
    .r_payload_o       ( r_payload_o     ),
    .lrdy_i            ( lrdy_i          ),
    .mem_req_o         ( mem_req         ),
    .mem_req_payload_o ( mem_req_payload ),
    .mem_gnt_i         ( mem_gnt         ),
    .mem_r_valid_i     ( mem_r_valid     ),
    .mem_r_payload_i   ( mem_r_payload   ),
    .flags_o           ( flags_o         )
  );

  tcdm_sram_bank u_bank (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .req_i         ( mem_req         ),
    .req_payload_i ( mem_req_payload ),
    .gnt_o         ( mem_gnt         ),
    .r_valid_o     ( mem_r_valid     ),
    .r_payload_o   ( mem_r_payload   )
  );

endmodule

/* verification/tb_tcdm_fifo_subsystem.sv */
/*
 * testbench for the TCDM FIFO subsystem
 * drives random requests through the decoupler and bank, checks every
 * response against a shadow memory model, plus flags, back-pressure and clear
 */

`timescale 1ns/1ps

module tb_tcdm_fifo_subsystem;

  import stream_pkg::*;
  import tcdm_pkg::*;

  localparam int DEPTH      = 4;
  localparam int WAIT_LIMIT = 2000;  // cycles per wait loop

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        clear_i;
  logic        req_i;
  tcdm_req_t   req_payload_i;
  logic        gnt_o;
  logic        r_valid_o;
  tcdm_rsp_t   r_payload_o;
  logic        lrdy_i;
  fifo_flags_t flags_o;

  tcdm_data_t  shadow_mem [MEM_WORDS];  // reference copy of the bank
  tcdm_rsp_t   exp_q [$];               // expected responses, in grant order
  int          consume_edge [int];      // edge number of each consumed response
  int          rsp_seen = 0;
  int          edge_cnt = 0;
  int          checks = 0;
  int          errors = 0;
  int          err_base = 0;
  int          tests = 0;
  logic [1:0]  lrdy_mode;               // 0 low, 1 high, 2 random
  logic [31:0] lfsr_state = 32'h26a3_3198;

  tcdm_fifo_subsystem #(
    .FIFO_DEPTH ( DEPTH )
  ) u_dut (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .req_i         ( req_i         ),
    .req_payload_i ( req_payload_i ),
    .gnt_o         ( gnt_o         ),
    .r_valid_o     ( r_valid_o     ),
    .r_payload_o   ( r_payload_o   ),
    .lrdy_i        ( lrdy_i        ),
    .flags_o       ( flags_o       )
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) edge_cnt <= edge_cnt + 1;

  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) lfsr_state = lfsr_state ^ 32'h8020_0003;  // x^32+x^22+x^2+x+1
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // 16 words spread over the whole bank
  function automatic tcdm_addr_t window_addr(input logic [3:0] k);
    return {k, 4'ha, 2'b00};
  endfunction

  function automatic tcdm_req_t rand_req(input logic may_write);
    tcdm_req_t req;
    req.add  = window_addr(4'(rand_bits(4)));
    req.data = rand_bits(32);
    req.be   = tcdm_be_t'(rand_bits(4));
    req.wen  = may_write ? lfsr_bit() : 1'b1;
    req.user = tcdm_user_t'(rand_bits(4));
    return req;
  endfunction

  // applies one request to the shadow memory, returns the response it must give
  function automatic tcdm_rsp_t ref_apply(input tcdm_req_t req);
    tcdm_data_t word;
    int         idx;
    tcdm_rsp_t  rsp;
    idx  = int'(req.add[ADDR_W-1:2]);
    word = shadow_mem[idx];
    if (!req.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req.be[b]) word[8*b +: 8] = req.data[8*b +: 8];
      end
      shadow_mem[idx] = word;
    end
    rsp.data = word;
    rsp.user = req.user;
    return rsp;
  endfunction

  function automatic fifo_flags_t flag_set(input logic e, input logic f, input logic p);
    fifo_flags_t fl;
    fl.empty        = e;
    fl.full         = f;
    fl.push_pending = p;
    return fl;
  endfunction

  task automatic check_rsp(input string name, input tcdm_rsp_t got, input tcdm_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flags(input string name, input fifo_flags_t got, input fifo_flags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic abort_run(input string why);
    errors++;
    $display("timeout: %s at %0t", why, $time);
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_base);
    err_base = errors;
  endtask

  // starts at a falling edge, returns at the falling edge after the transfer
  task automatic send_req(input tcdm_req_t req, output int grant_edge);
    int n;
    n = 0;
    req_i = 1'b1;
    req_payload_i = req;
    while (!gnt_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!gnt_o) begin
      abort_run("gnt_o stayed low for a pending request");
    end else begin
      grant_edge = edge_cnt + 1;  // transfer on the coming rising edge
      exp_q.push_back(ref_apply(req));
      @(negedge clk_i);
      req_i = 1'b0;
    end
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || r_valid_o) && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0 || r_valid_o) abort_run({"responses still missing in ", what});
  endtask

  // response side: picks lrdy_i each cycle and checks what gets consumed
  initial begin
    lrdy_i = 1'b0;
    forever begin
      @(negedge clk_i);
      case (lrdy_mode)
        2'd0:    lrdy_i = 1'b0;
        2'd1:    lrdy_i = 1'b1;
        default: lrdy_i = lfsr_bit();
      endcase
      if (r_valid_o && lrdy_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response with user 0x%h arrived with no request pending", r_payload_o.user);
        end else begin
          check_rsp("r_payload_o", r_payload_o, exp_q.pop_front());
        end
        consume_edge[rsp_seen] = edge_cnt + 1;
        rsp_seen++;
      end
    end
  end

  initial begin
    tcdm_req_t req;
    int        g;
    int        g0;
    int        s0;
    int        accepted;
    int        low_run;

    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    req_i         = 1'b0;
    req_payload_i = '0;
    lrdy_mode     = 2'd1;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    check_bit("gnt_o", gnt_o, 1'b1);
    check_bit("r_valid_o", r_valid_o, 1'b0);
    check_flags("flags_o", flags_o, flag_set(1'b1, 1'b0, 1'b0));
    req = '{add: 10'h3fc, data: 32'hcafe_f00d, be: 4'hf, wen: 1'b0, user: 4'h3};
    send_req(req, g);
    req = '{add: 10'h3fc, data: 32'h0, be: 4'h0, wen: 1'b1, user: 4'h9};
    send_req(req, g);
    wait_drain("single access");
    end_test("reset and single access");

    for (int k = 0; k < 16; k++) begin
      req = '{add: window_addr(4'(k)), data: rand_bits(32), be: 4'hf, wen: 1'b0,
              user: tcdm_user_t'(k)};
      send_req(req, g);
    end
    for (int k = 0; k < 16; k++) begin
      req = rand_req(1'b1);
      req.wen = 1'b0;  // partial write under random enables
      send_req(req, g);
    end
    for (int k = 0; k < 16; k++) begin
      req = rand_req(1'b0);
      req.add = window_addr(4'(k));
      send_req(req, g);
    end
    wait_drain("byte enables");
    end_test("byte enables");

    s0 = rsp_seen;
    for (int k = 0; k < 64; k++) begin
      send_req(rand_req(1'b1), g);
      if (k == 0) g0 = g;
    end
    wait_drain("back-to-back");
    if (consume_edge[s0] - g0 != 3) begin
      errors++;
      $display("first response was taken %0d edges after its grant instead of 3",
               consume_edge[s0] - g0);
    end
    end_test("back-to-back traffic");

    lrdy_mode <= 2'd0;
    @(negedge clk_i);
    accepted = 0;
    low_run  = 0;
    req_i = 1'b1;
    req_payload_i = rand_req(1'b1);
    while (low_run < 8 && accepted <= 2 * DEPTH + 1) begin
      if (gnt_o) begin
        exp_q.push_back(ref_apply(req_payload_i));
        accepted++;
        low_run = 0;
        @(negedge clk_i);
        req_payload_i = rand_req(1'b1);
      end else begin
        low_run++;
        @(negedge clk_i);
      end
    end
    if (accepted > 2 * DEPTH + 1) begin
      errors++;
      $display("gnt_o still high after %0d requests with lrdy_i low", accepted);
    end
    check_bit("gnt_o", gnt_o, 1'b0);
    check_flags("flags_o", flags_o, flag_set(1'b0, 1'b1, 1'b1));
    req_i = 1'b0;
    lrdy_mode <= 2'd2;
    for (int k = 0; k < 32; k++) send_req(rand_req(1'b1), g);
    wait_drain("back-pressure");
    lrdy_mode <= 2'd1;
    end_test("back-pressure");

    lrdy_mode <= 2'd0;
    @(negedge clk_i);
    for (int k = 0; k < 6; k++) send_req(rand_req(1'b0), g);  // reads keep memory as is
    repeat (4) @(negedge clk_i);
    check_bit("r_valid_o", r_valid_o, 1'b1);  // responses parked before the clear
    check_rsp("r_payload_o", r_payload_o, exp_q[0]);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    check_bit("r_valid_o", r_valid_o, 1'b0);
    check_flags("flags_o", flags_o, flag_set(1'b1, 1'b0, 1'b0));
    exp_q.delete();  // parked responses are gone
    lrdy_mode <= 2'd1;
    req = '{add: 10'h3fc, data: 32'h0, be: 4'h0, wen: 1'b1, user: 4'h5};
    send_req(req, g);
    send_req(rand_req(1'b0), g);
    wait_drain("clear");
    end_test("clear");

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* flist.f */
hdl/stream_pkg.sv
hdl/tcdm_pkg.sv
hdl/stream_fifo.sv
hdl/tcdm_fifo_decoupler.sv
hdl/tcdm_sram_bank.sv
hdl/tcdm_fifo_subsystem.sv
verification/tb_tcdm_fifo_subsystem.sv
